// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = lstmNetworkTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: cellLane.sv
`timescale 1ns/1ps
`default_nettype none

module cellLane (
    input  logic            clock,
    input  logic            reset,
    input  logic            preValid,
    input  lstmPkg::fixed_t preZ,
    input  lstmPkg::fixed_t preI,
    input  lstmPkg::fixed_t preF,
    input  lstmPkg::fixed_t preO,
    output lstmPkg::fixed_t hiddenOut,
    output logic            laneValid
);

    import lstmPkg::*;

    fixed_t tanhZ;
    fixed_t sigI;
    fixed_t sigF;
    fixed_t sigO1;
    fixed_t sigO2;
    fixed_t cellState;
    logic   valid1;
    logic   valid2;

    // x/4 + 0.5, clamped to [0, 1]
    function automatic fixed_t hardSigmoid(fixed_t x);
        fixed_t shifted;
        shifted = (x >>> 2) + HALF;
        if (shifted < 0)
            return '0;
        else if (shifted > ONE)
            return ONE;
        return shifted;
    endfunction

    function automatic fixed_t hardTanh(fixed_t x);
        if (x > ONE)
            return ONE;
        else if (x < -ONE)
            return -ONE;
        return x;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            laneValid <= 1'b0;
        end else begin
            valid1 <= preValid;
            valid2 <= valid1;
            laneValid <= valid2;
        end
    end

    // Stage 1 nonlinearities
    always_ff @(posedge clock) begin
        if (preValid) begin
            tanhZ <= hardTanh(preZ);
            sigI <= hardSigmoid(preI);
            sigF <= hardSigmoid(preF);
            sigO1 <= hardSigmoid(preO);
        end
    end

    // Stage 2 cell update, state carried across samples
    always_ff @(posedge clock) begin
        if (reset) begin
            cellState <= '0;
        end else if (valid1) begin
            cellState <= mulQ(tanhZ, sigI) + mulQ(cellState, sigF);
        end
    end

    always_ff @(posedge clock) begin
        if (valid1)
            sigO2 <= sigO1;
    end

    // Stage 3 hidden output
    always_ff @(posedge clock) begin
        if (valid2)
            hiddenOut <= mulQ(sigO2, hardTanh(cellState));
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
lstmPkg.sv
weightMemory.sv
gateAccumulator.sv
cellLane.sv
outputCollector.sv
lstmNetwork.sv
lstmNetworkTb.sv

// File: gateAccumulator.sv
`timescale 1ns/1ps
`default_nettype none

`include "lstm_cfg.svh"

module gateAccumulator (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    newSample,
    input  logic [`INPUT_SZ*lstmPkg::BITWIDTH-1:0]  inputVec,
    input  logic [`HIDDEN_SZ*lstmPkg::BITWIDTH-1:0] hiddenVec,
    output logic [lstmPkg::COL_W-1:0]               readColumn,
    input  lstmPkg::fixed_t                         columnWeights [4][`HIDDEN_SZ],
    output lstmPkg::fixed_t                         preActivation [4][`HIDDEN_SZ],
    output logic                                    preValid
);

    import lstmPkg::*;

    typedef enum logic [1:0] {IDLE, READING, ACCUM} state_e;

    state_e                                  state;
    logic [COL_W-1:0]                        readCol;
    logic [COL_W-1:0]                        dataCol;
    logic [`INPUT_SZ*BITWIDTH-1:0]           sampleInput;
    logic [`HIDDEN_SZ*BITWIDTH-1:0]          sampleHidden;
    logic [(COLUMNS+1)*BITWIDTH-1:0]         operandVec;
    fixed_t                                  operand;
    logic                                    accept;
    logic                                    accumulating;

    assign accept = (state == IDLE) && newSample;
    assign accumulating = (state == READING) || (state == ACCUM);

    // Column 0 is addressed while idle, so its data is ready right after accept
    assign readColumn = readCol;

    // The bias column is weighted by a constant one
    assign operandVec = {ONE, sampleHidden, sampleInput};
    assign operand = operandVec[dataCol*BITWIDTH +: BITWIDTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            readCol <= '0;
            dataCol <= '0;
            preValid <= 1'b0;
        end else begin
            preValid <= 1'b0;
            case (state)
                IDLE: begin
                    if (newSample) begin
                        state <= READING;
                        readCol <= COL_W'(1);
                        dataCol <= '0;
                    end
                end
                READING: begin
                    dataCol <= dataCol + 1'b1;
                    if (readCol == COLUMNS) begin
                        readCol <= '0;
                        state <= ACCUM;
                    end else begin
                        readCol <= readCol + 1'b1;
                    end
                end
                ACCUM: begin
                    // Bias column arrives in this cycle
                    state <= IDLE;
                    preValid <= 1'b1;
                end
                default: begin
                    state <= IDLE;
                    readCol <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            sampleInput <= inputVec;
            sampleHidden <= hiddenVec;
            for (int g = 0; g < 4; g++) begin
                for (int u = 0; u < `HIDDEN_SZ; u++) begin
                    preActivation[g][u] <= '0;
                end
            end
        end else if (accumulating) begin
            for (int g = 0; g < 4; g++) begin
                for (int u = 0; u < `HIDDEN_SZ; u++) begin
                    preActivation[g][u] <= preActivation[g][u]
                                           + mulQ(columnWeights[g][u], operand);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: lstmNetwork.sv
`timescale 1ns/1ps
`default_nettype none

`include "lstm_cfg.svh"

module lstmNetwork (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [`INPUT_SZ*lstmPkg::BITWIDTH-1:0]  inputVec,
    input  logic                                    newSample,
    input  logic                                    weightWrite,
    input  lstmPkg::gate_e                          weightGate,
    input  logic [lstmPkg::UNIT_W-1:0]              weightUnit,
    input  logic [lstmPkg::COL_W-1:0]               weightColumn,
    input  lstmPkg::fixed_t                         weightData,
    output logic [`HIDDEN_SZ*lstmPkg::BITWIDTH-1:0] outputVec,
    output logic                                    dataoutReady
);

    import lstmPkg::*;

    logic [COL_W-1:0]               readColumn;
    fixed_t                         columnWeights [4][`HIDDEN_SZ];
    fixed_t                         preActivation [4][`HIDDEN_SZ];
    logic                           preValid;
    fixed_t                         laneHidden [`HIDDEN_SZ];
    logic [`HIDDEN_SZ-1:0]          laneValid;
    logic [`HIDDEN_SZ*BITWIDTH-1:0] hiddenVec;

    weightMemory weights0 (
        .clock         (clock),
        .reset         (reset),
        .weightWrite   (weightWrite),
        .weightGate    (weightGate),
        .weightUnit    (weightUnit),
        .weightColumn  (weightColumn),
        .weightData    (weightData),
        .readColumn    (readColumn),
        .columnWeights (columnWeights)
    );

    gateAccumulator gates0 (
        .clock         (clock),
        .reset         (reset),
        .newSample     (newSample),
        .inputVec      (inputVec),
        .hiddenVec     (hiddenVec),
        .readColumn    (readColumn),
        .columnWeights (columnWeights),
        .preActivation (preActivation),
        .preValid      (preValid)
    );

    for (genvar j = 0; j < `HIDDEN_SZ; j++) begin : lane
        cellLane cell0 (
            .clock     (clock),
            .reset     (reset),
            .preValid  (preValid),
            .preZ      (preActivation[GATE_Z][j]),
            .preI      (preActivation[GATE_I][j]),
            .preF      (preActivation[GATE_F][j]),
            .preO      (preActivation[GATE_O][j]),
            .hiddenOut (laneHidden[j]),
            .laneValid (laneValid[j])
        );
    end

    outputCollector collector0 (
        .clock        (clock),
        .reset        (reset),
        .laneValid    (laneValid),
        .laneHidden   (laneHidden),
        .outputVec    (outputVec),
        .hiddenVec    (hiddenVec),
        .dataoutReady (dataoutReady)
    );

endmodule

`default_nettype wire

// File: lstmNetworkTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lstm_cfg.svh"

module lstmNetworkTb;

    import lstmPkg::*;

    localparam int CLOCK_PERIOD = 100;
    localparam int VEC_W = `HIDDEN_SZ * BITWIDTH;
    localparam int IN_W = `INPUT_SZ * BITWIDTH;
    localparam int LATENCY = COLUMNS + 6;
    localparam int TIMEOUT_CYCLES = 4 * LATENCY;
    localparam int ONE_I = 1 << `QM;
    localparam int HALF_I = 1 << (`QM - 1);
    // Weights within +-0.5, inputs within +-2
    localparam int WEIGHT_SPAN = ONE_I / 2;
    localparam int INPUT_SPAN = 2 * ONE_I;
    localparam int BIAS_BIG = 8 * ONE_I;

    logic             clock;
    logic             reset;
    logic [IN_W-1:0]  inputVec;
    logic             newSample;
    logic             weightWrite;
    gate_e            weightGate;
    logic [UNIT_W-1:0] weightUnit;
    logic [COL_W-1:0] weightColumn;
    fixed_t           weightData;
    logic [VEC_W-1:0] outputVec;
    logic             dataoutReady;

    // Model copy of the weights and the recurrent state
    int modelW [4][`HIDDEN_SZ][COLUMNS+1];
    int savedW [4][`HIDDEN_SZ][COLUMNS+1];
    int modelH [`HIDDEN_SZ];
    int modelC [`HIDDEN_SZ];

    logic [VEC_W-1:0] expectQ [$];
    logic [VEC_W-1:0] lastExpected;
    logic [VEC_W-1:0] firstResult;
    logic [IN_W-1:0]  firstInput;
    logic [31:0]      lcgState;
    int               errorCount;
    int               checkCount;
    int               resultCount;
    bit               timedOut;

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    lstmNetwork dut0 (
        .clock        (clock),
        .reset        (reset),
        .inputVec     (inputVec),
        .newSample    (newSample),
        .weightWrite  (weightWrite),
        .weightGate   (weightGate),
        .weightUnit   (weightUnit),
        .weightColumn (weightColumn),
        .weightData   (weightData),
        .outputVec    (outputVec),
        .dataoutReady (dataoutReady)
    );

    function automatic int wrapWord(longint value);
        logic signed [BITWIDTH-1:0] word;
        word = value[BITWIDTH-1:0];
        return int'(word);
    endfunction

    function automatic int fixedMul(int a, int b);
        longint full;
        full = longint'(a) * longint'(b);
        return wrapWord(full >>> `QM);
    endfunction

    function automatic int sigmoidRef(int x);
        int y;
        y = (x >>> 2) + HALF_I;
        if (y < 0)
            y = 0;
        else if (y > ONE_I)
            y = ONE_I;
        return y;
    endfunction

    function automatic int tanhRef(int x);
        if (x > ONE_I)
            return ONE_I;
        else if (x < -ONE_I)
            return -ONE_I;
        return x;
    endfunction

    // One time step of the cell, advancing the model's own h and c
    function automatic logic [VEC_W-1:0] modelStep(logic [IN_W-1:0] sample);
        int operand [COLUMNS];
        int pre [4];
        int cNew;
        int hNew;
        logic signed [BITWIDTH-1:0] field;
        logic [VEC_W-1:0] result;
        for (int k = 0; k < `INPUT_SZ; k++) begin
            field = sample[k*BITWIDTH +: BITWIDTH];
            operand[k] = int'(field);
        end
        for (int j = 0; j < `HIDDEN_SZ; j++)
            operand[`INPUT_SZ + j] = modelH[j];
        result = '0;
        for (int u = 0; u < `HIDDEN_SZ; u++) begin
            for (int g = 0; g < 4; g++) begin
                pre[g] = modelW[g][u][COLUMNS];
                for (int k = 0; k < COLUMNS; k++)
                    pre[g] = wrapWord(pre[g] + fixedMul(modelW[g][u][k], operand[k]));
            end
            cNew = wrapWord(fixedMul(tanhRef(pre[0]), sigmoidRef(pre[1]))
                            + fixedMul(modelC[u], sigmoidRef(pre[2])));
            hNew = fixedMul(sigmoidRef(pre[3]), tanhRef(cNew));
            modelC[u] = cNew;
            modelH[u] = hNew;
            result[u*BITWIDTH +: BITWIDTH] = hNew[BITWIDTH-1:0];
        end
        return result;
    endfunction

    function automatic logic [31:0] lcgNext(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Uniform value in -span to span
    function automatic int randomValue(int span);
        int raw;
        lcgState = lcgNext(lcgState);
        raw = int'(lcgState[30:8]);
        return raw % (2 * span + 1) - span;
    endfunction

    function automatic logic [IN_W-1:0] randomInput();
        int v;
        logic [IN_W-1:0] vec;
        for (int k = 0; k < `INPUT_SZ; k++) begin
            v = randomValue(INPUT_SPAN);
            vec[k*BITWIDTH +: BITWIDTH] = v[BITWIDTH-1:0];
        end
        return vec;
    endfunction

    task automatic stepClock();
        @(posedge clock);
        #1;
    endtask

    task automatic checkValue(string signalName, logic [VEC_W-1:0] actual,
                              logic [VEC_W-1:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, signalName, actual, expected);
            errorCount++;
        end
    endtask

    task automatic clearModel();
        for (int g = 0; g < 4; g++)
            for (int u = 0; u < `HIDDEN_SZ; u++)
                for (int c = 0; c <= COLUMNS; c++)
                    modelW[g][u][c] = 0;
        for (int j = 0; j < `HIDDEN_SZ; j++) begin
            modelH[j] = 0;
            modelC[j] = 0;
        end
        expectQ.delete();
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (4) stepClock();
        reset = 1'b0;
        clearModel();
    endtask

    task automatic writeWeight(int gate, int unit, int column, int value);
        weightWrite = 1'b1;
        weightGate = gate_e'(gate);
        weightUnit = UNIT_W'(unit);
        weightColumn = COL_W'(column);
        weightData = fixed_t'(value);
        modelW[gate][unit][column] = value;
        stepClock();
        weightWrite = 1'b0;
    endtask

    // Saturating biases alternate in sign over gates and units
    task automatic loadWeights(bit saturate);
        int value;
        for (int g = 0; g < 4; g++) begin
            for (int u = 0; u < `HIDDEN_SZ; u++) begin
                for (int c = 0; c <= COLUMNS; c++) begin
                    if (saturate && c == COLUMNS)
                        value = (((g + u) % 2 == 0) ? 1 : -1) * (BIAS_BIG + randomValue(ONE_I));
                    else
                        value = randomValue(WEIGHT_SPAN);
                    writeWeight(g, u, c, value);
                end
            end
        end
    endtask

    task automatic reloadSavedWeights();
        for (int g = 0; g < 4; g++)
            for (int u = 0; u < `HIDDEN_SZ; u++)
                for (int c = 0; c <= COLUMNS; c++)
                    writeWeight(g, u, c, savedW[g][u][c]);
    endtask

    // Latency counts rising edges from the newSample cycle to dataoutReady
    task automatic runSample(logic [IN_W-1:0] vec, int busyAt,
                             output int latency, output int width);
        bit seen;
        bit stillHigh;
        inputVec = vec;
        newSample = 1'b1;
        lastExpected = modelStep(vec);
        expectQ.push_back(lastExpected);
        latency = 0;
        width = 0;
        seen = 1'b0;
        while (!seen && latency < TIMEOUT_CYCLES) begin
            stepClock();
            latency++;
            // A second strobe lands while the accumulator is busy
            newSample = (busyAt > 0) && (latency == busyAt);
            if (newSample)
                inputVec = ~vec;
            seen = dataoutReady;
        end
        if (!seen) begin
            $display("Timeout: no dataoutReady within %0d cycles of newSample", TIMEOUT_CYCLES);
            timedOut = 1'b1;
        end else begin
            width = 1;
            stillHigh = 1'b1;
            while (stillHigh && width < TIMEOUT_CYCLES) begin
                stepClock();
                stillHigh = dataoutReady;
                if (stillHigh)
                    width++;
            end
        end
    endtask

    task automatic checkRange();
        logic signed [BITWIDTH-1:0] field;
        for (int j = 0; j < `HIDDEN_SZ; j++) begin
            field = outputVec[j*BITWIDTH +: BITWIDTH];
            checkCount++;
            if (int'(field) > ONE_I || int'(field) < -ONE_I) begin
                $display("Unit %0d output %0d is outside -1 to 1 at %0t", j, field, $time);
                errorCount++;
            end
        end
    endtask

    task automatic reportTest(int number, string name, int errorsBefore);
        $display("Test %0d %s finished with %0d errors", number, name, errorCount - errorsBefore);
    endtask

    // Every result is compared with the oldest pending model result
    always @(negedge clock) begin : compareResults
        logic [VEC_W-1:0] expected;
        if (!reset && dataoutReady) begin
            resultCount++;
            if (expectQ.size() == 0) begin
                $display("Unexpected dataoutReady pulse at %0t with no sample pending", $time);
                errorCount++;
            end else begin
                expected = expectQ.pop_front();
                checkValue("outputVec", outputVec, expected);
            end
        end
    end

    initial begin
        int errorsBefore;
        int resultsBefore;
        int latency;
        int width;
        clock = 1'b0;
        reset = 1'b1;
        inputVec = '0;
        newSample = 1'b0;
        weightWrite = 1'b0;
        weightGate = GATE_Z;
        weightUnit = '0;
        weightColumn = '0;
        weightData = '0;
        lcgState = 32'ha48;
        errorCount = 0;
        checkCount = 0;
        resultCount = 0;
        timedOut = 1'b0;
        applyReset();

        errorsBefore = errorCount;
        runSample(randomInput(), 0, latency, width);
        checkValue("outputVec", outputVec, '0);
        checkValue("dataoutReady width", width, 1);
        reportTest(1, "zero weights", errorsBefore);

        if (!timedOut) begin
            errorsBefore = errorCount;
            loadWeights(1'b0);
            savedW = modelW;
            firstInput = randomInput();
            runSample(firstInput, 0, latency, width);
            firstResult = lastExpected;
            reportTest(2, "single sample", errorsBefore);
        end

        if (!timedOut) begin
            errorsBefore = errorCount;
            for (int n = 0; n < 8 && !timedOut; n++)
                runSample(randomInput(), 0, latency, width);
            reportTest(3, "recurrence", errorsBefore);
        end

        if (!timedOut) begin
            errorsBefore = errorCount;
            resultsBefore = resultCount;
            runSample(randomInput(), 3, latency, width);
            repeat (2 * LATENCY) stepClock();
            checkValue("dataoutReady latency", latency, LATENCY);
            checkValue("dataoutReady width", width, 1);
            checkValue("result count", resultCount - resultsBefore, 1);
            reportTest(4, "timing", errorsBefore);
        end

        if (!timedOut) begin
            errorsBefore = errorCount;
            loadWeights(1'b1);
            for (int n = 0; n < 4 && !timedOut; n++) begin
                runSample(randomInput(), 0, latency, width);
                checkRange();
            end
            reportTest(5, "saturation", errorsBefore);
        end

        if (!timedOut) begin
            errorsBefore = errorCount;
            runSample(randomInput(), 0, latency, width);
            resultsBefore = resultCount;
            // Abort a sample halfway through accumulation
            inputVec = randomInput();
            newSample = 1'b1;
            stepClock();
            newSample = 1'b0;
            repeat (4) stepClock();
            applyReset();
            repeat (2 * LATENCY) stepClock();
            checkValue("result count", resultCount - resultsBefore, 0);
            checkValue("outputVec", outputVec, '0);
            reloadSavedWeights();
            runSample(firstInput, 0, latency, width);
            checkValue("outputVec", outputVec, firstResult);
            reportTest(6, "reset mid-sequence", errorsBefore);
        end

        $display("Checks: %0d, results: %0d, errors: %0d", checkCount, resultCount, errorCount);
        if (errorCount == 0 && !timedOut)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: lstmPkg.sv
`default_nettype none

`include "lstm_cfg.svh"

package lstmPkg;

    localparam int BITWIDTH = `QN + `QM + 1;
    localparam int COLUMNS = `INPUT_SZ + `HIDDEN_SZ;
    localparam int COL_W = $clog2(COLUMNS + 1);
    localparam int UNIT_W = ($clog2(`HIDDEN_SZ) > 0) ? $clog2(`HIDDEN_SZ) : 1;

    typedef logic signed [BITWIDTH-1:0] fixed_t;
    typedef logic signed [2*BITWIDTH-1:0] product_t;

    typedef enum logic [1:0] {GATE_Z, GATE_I, GATE_F, GATE_O} gate_e;

    localparam fixed_t ONE = fixed_t'(1 << `QM);
    localparam fixed_t HALF = fixed_t'(1 << (`QM - 1));

    // Full product rescaled to Q6.11, upper bits wrap away
    function automatic fixed_t mulQ(fixed_t a, fixed_t b);
        product_t full;
        full = a * b;
        return fixed_t'(full >>> `QM);
    endfunction

endpackage

`default_nettype wire

// File: lstm_cfg.svh
`ifndef LSTM_CFG_SVH
`define LSTM_CFG_SVH

// Q6.11 fixed point format
`define QN 6
`define QM 11

// Integer bits plus fraction bits plus sign give an 18-bit word

// Network dimensions
`define INPUT_SZ 2
`define HIDDEN_SZ 4

// Columns of the weight store are the inputs, then the hidden units,
// then one bias column

`endif

// File: outputCollector.sv
`timescale 1ns/1ps
`default_nettype none

`include "lstm_cfg.svh"

module outputCollector (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [`HIDDEN_SZ-1:0]                   laneValid,
    input  lstmPkg::fixed_t                         laneHidden [`HIDDEN_SZ],
    output logic [`HIDDEN_SZ*lstmPkg::BITWIDTH-1:0] outputVec,
    output logic [`HIDDEN_SZ*lstmPkg::BITWIDTH-1:0] hiddenVec,
    output logic                                    dataoutReady
);

    import lstmPkg::*;

    logic [`HIDDEN_SZ*BITWIDTH-1:0] hiddenState;
    logic                           allValid;

    // Lanes run in lockstep, so all bits rise together
    assign allValid = &laneValid;

    always_ff @(posedge clock) begin
        if (reset) begin
            hiddenState <= '0;
            dataoutReady <= 1'b0;
        end else begin
            dataoutReady <= allValid;
            if (allValid) begin
                for (int j = 0; j < `HIDDEN_SZ; j++) begin
                    hiddenState[j*BITWIDTH +: BITWIDTH] <= laneHidden[j];
                end
            end
        end
    end

    // Same vector is the result and the recurrent input
    assign outputVec = hiddenState;
    assign hiddenVec = hiddenState;

endmodule

`default_nettype wire

// File: weightMemory.sv
`timescale 1ns/1ps
`default_nettype none

`include "lstm_cfg.svh"

module weightMemory (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          weightWrite,
    input  lstmPkg::gate_e                weightGate,
    input  logic [lstmPkg::UNIT_W-1:0]    weightUnit,
    input  logic [lstmPkg::COL_W-1:0]     weightColumn,
    input  lstmPkg::fixed_t               weightData,
    input  logic [lstmPkg::COL_W-1:0]     readColumn,
    output lstmPkg::fixed_t               columnWeights [4][`HIDDEN_SZ]
);

    import lstmPkg::*;

    // One word per gate, unit and column, the last column being the bias
    fixed_t store [4][`HIDDEN_SZ][COLUMNS+1];

    logic writeInRange;

    assign writeInRange = (weightColumn <= COLUMNS) && (weightUnit < `HIDDEN_SZ);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int g = 0; g < 4; g++) begin
                for (int u = 0; u < `HIDDEN_SZ; u++) begin
                    for (int c = 0; c <= COLUMNS; c++) begin
                        store[g][u][c] <= '0;
                    end
                end
            end
        end else if (weightWrite && writeInRange) begin
            store[weightGate][weightUnit][weightColumn] <= weightData;
        end
    end

    // Whole column for all gates and units, one cycle after the address
    always_ff @(posedge clock) begin
        for (int g = 0; g < 4; g++) begin
            for (int u = 0; u < `HIDDEN_SZ; u++) begin
                columnWeights[g][u] <= store[g][u][readColumn];
            end
        end
    end

endmodule

`default_nettype wire
